/* files.f */
+incdir+hw
hw/dsp_types_pkg.sv
hw/beam_pkg.sv
hw/beam_lane_if.sv
hw/channel_weighter.sv
hw/beam_combiner.sv
hw/beam_former_top.sv
tests/beam_former_tb.sv

/* hw/beam_combiner.sv */
`default_nettype none

`include "beam_settings.svh"

// joins the weighted channel streams and averages them into one beam beat
// all channels move together so the n-th beam beat uses the n-th beat of each channel
module beam_combiner (
    input  logic                     clock,
    input  logic                     resetn,
    beam_lane_if.sink                ch [`BEAM_CHANNELS],
    output logic                     beam_valid,
    input  logic                     beam_ready,
    output beam_pkg::complex_beat_t  beam_beat
);

    // dividing by the channel count is a plain arithmetic shift
    localparam int SHIFT = $clog2(`BEAM_CHANNELS);
    localparam int ACC_WIDTH = `BEAM_SAMPLE_WIDTH + SHIFT;
    localparam logic signed [ACC_WIDTH-1:0] ROUND = 1 <<< (SHIFT - 1);

    logic [`BEAM_CHANNELS-1:0] ch_valid;
    beam_pkg::complex_beat_t   ch_beat [`BEAM_CHANNELS];
    beam_pkg::complex_beat_t   sum_beat;
    beam_pkg::complex_beat_t   beat_q;
    logic                      valid_q;
    logic                      take;

    // a joint transfer needs every channel valid and room in the output register
    assign take = (&ch_valid) && (!valid_q || beam_ready);

    for (genvar g = 0; g < `BEAM_CHANNELS; g++) begin : g_ch
        assign ch_valid[g]  = ch[g].valid;
        assign ch_beat[g]   = ch[g].beat;
        assign ch[g].ready  = take;

        // a weighter that offered a beat keeps it until the joint transfer
        // a dropped or altered beat would put the channels out of step for good
        a_ch_held: assert property (
            @(posedge clock) disable iff (!resetn)
            ch_valid[g] && !take |=> ch_valid[g] && $stable(ch_beat[g])
        );
    end

    // sum each sample position over the channels, then round and divide
    always_comb begin
        logic signed [ACC_WIDTH-1:0] acc_re;
        logic signed [ACC_WIDTH-1:0] acc_im;
        dsp_types_pkg::sample_t      s_re;
        dsp_types_pkg::sample_t      s_im;
        for (int i = 0; i < `BEAM_SAMPLES_PER_BEAT; i++) begin
            acc_re = '0;
            acc_im = '0;
            for (int c = 0; c < `BEAM_CHANNELS; c++) begin
                s_re   = ch_beat[c].re.samples[i];
                s_im   = ch_beat[c].im.samples[i];
                acc_re = acc_re + s_re;
                acc_im = acc_im + s_im;
            end
            // the average of in-range samples is in range, so no clipping is needed
            acc_re = (acc_re + ROUND) >>> SHIFT;
            acc_im = (acc_im + ROUND) >>> SHIFT;
            sum_beat.re.samples[i] = acc_re[`BEAM_SAMPLE_WIDTH-1:0];
            sum_beat.im.samples[i] = acc_im[`BEAM_SAMPLE_WIDTH-1:0];
        end
    end

    // beam valid rises one cycle after the joint transfer
    always_ff @(posedge clock) begin
        if (!resetn) begin
            valid_q <= 1'b0;
        end else if (take) begin
            valid_q <= 1'b1;
        end else if (beam_ready) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (take) begin
            beat_q <= sum_beat;
        end
    end

    assign beam_valid = valid_q;
    assign beam_beat  = beat_q;

    // the beam beat waits unchanged while the consumer holds off
    a_beam_held: assert property (
        @(posedge clock) disable iff (!resetn)
        beam_valid && !beam_ready |=> beam_valid && $stable(beam_beat)
    );

endmodule

`default_nettype wire

/* hw/beam_former_top.sv */
`default_nettype none

`include "beam_settings.svh"

// four-channel complex beamformer
// each channel is weighted in its own pipeline stage, then the combiner averages them
module beam_former_top (
    input  logic                         clock,
    input  logic                         resetn,

    input  logic                         ch00_valid,
    output logic                         ch00_ready,
    input  logic [`BEAM_LANE_WIDTH-1:0]  ch00_real,
    input  logic [`BEAM_LANE_WIDTH-1:0]  ch00_imag,
    input  logic [`BEAM_SAMPLE_WIDTH-1:0] ch00_weight_real,
    input  logic [`BEAM_SAMPLE_WIDTH-1:0] ch00_weight_imag,

    input  logic                         ch01_valid,
    output logic                         ch01_ready,
    input  logic [`BEAM_LANE_WIDTH-1:0]  ch01_real,
    input  logic [`BEAM_LANE_WIDTH-1:0]  ch01_imag,
    input  logic [`BEAM_SAMPLE_WIDTH-1:0] ch01_weight_real,
    input  logic [`BEAM_SAMPLE_WIDTH-1:0] ch01_weight_imag,

    input  logic                         ch20_valid,
    output logic                         ch20_ready,
    input  logic [`BEAM_LANE_WIDTH-1:0]  ch20_real,
    input  logic [`BEAM_LANE_WIDTH-1:0]  ch20_imag,
    input  logic [`BEAM_SAMPLE_WIDTH-1:0] ch20_weight_real,
    input  logic [`BEAM_SAMPLE_WIDTH-1:0] ch20_weight_imag,

    input  logic                         ch21_valid,
    output logic                         ch21_ready,
    input  logic [`BEAM_LANE_WIDTH-1:0]  ch21_real,
    input  logic [`BEAM_LANE_WIDTH-1:0]  ch21_imag,
    input  logic [`BEAM_SAMPLE_WIDTH-1:0] ch21_weight_real,
    input  logic [`BEAM_SAMPLE_WIDTH-1:0] ch21_weight_imag,

    output logic                         beam_valid,
    input  logic                         beam_ready,
    output logic [`BEAM_LANE_WIDTH-1:0]  beam_real,
    output logic [`BEAM_LANE_WIDTH-1:0]  beam_imag
);

    // channel order inside the design: 00, 01, 20, 21
    logic [`BEAM_CHANNELS-1:0]  ch_valid;
    logic [`BEAM_CHANNELS-1:0]  ch_ready;
    beam_pkg::complex_beat_t    ch_beat [`BEAM_CHANNELS];
    beam_pkg::complex_weight_t  ch_weight [`BEAM_CHANNELS];
    beam_pkg::complex_beat_t    beam_beat;

    beam_lane_if lane [`BEAM_CHANNELS] ();

    assign ch_valid = {ch21_valid, ch20_valid, ch01_valid, ch00_valid};

    // the ports carry the flat view of each lane
    assign ch_beat[0].re.bits = ch00_real;
    assign ch_beat[0].im.bits = ch00_imag;
    assign ch_beat[1].re.bits = ch01_real;
    assign ch_beat[1].im.bits = ch01_imag;
    assign ch_beat[2].re.bits = ch20_real;
    assign ch_beat[2].im.bits = ch20_imag;
    assign ch_beat[3].re.bits = ch21_real;
    assign ch_beat[3].im.bits = ch21_imag;

    assign ch_weight[0] = '{re: ch00_weight_real, im: ch00_weight_imag};
    assign ch_weight[1] = '{re: ch01_weight_real, im: ch01_weight_imag};
    assign ch_weight[2] = '{re: ch20_weight_real, im: ch20_weight_imag};
    assign ch_weight[3] = '{re: ch21_weight_real, im: ch21_weight_imag};

    assign ch00_ready = ch_ready[0];
    assign ch01_ready = ch_ready[1];
    assign ch20_ready = ch_ready[2];
    assign ch21_ready = ch_ready[3];

    for (genvar g = 0; g < `BEAM_CHANNELS; g++) begin : g_weighter
        channel_weighter channel_weighter_i (
            .clock    (clock),
            .resetn   (resetn),
            .in_valid (ch_valid[g]),
            .in_ready (ch_ready[g]),
            .in_beat  (ch_beat[g]),
            .weight   (ch_weight[g]),
            .out      (lane[g])
        );
    end

    beam_combiner beam_combiner_i (
        .clock      (clock),
        .resetn     (resetn),
        .ch         (lane),
        .beam_valid (beam_valid),
        .beam_ready (beam_ready),
        .beam_beat  (beam_beat)
    );

    assign beam_real = beam_beat.re.bits;
    assign beam_imag = beam_beat.im.bits;

endmodule

`default_nettype wire

/* hw/beam_lane_if.sv */
`default_nettype none

// carries one complex beat from a weighter to the combiner
// a beat moves on a rising edge where valid and ready are both high
interface beam_lane_if;

    logic valid;
    logic ready;
    beam_pkg::complex_beat_t beat;

    // the producing side holds valid and beat steady until the transfer
    modport source (
        output valid,
        output beat,
        input  ready
    );

    // the consuming side decides when the beat is taken
    modport sink (
        input  valid,
        input  beat,
        output ready
    );

endinterface

`default_nettype wire

/* hw/beam_pkg.sv */
`default_nettype none

// channel arrangement: how a complex beat and a complex weight are laid out
package beam_pkg;

    // one complex beat, a real lane and an imaginary lane of equal length
    // the real lane occupies the upper half of the packed word
    typedef struct packed {
        dsp_types_pkg::sample_lane_u re;
        dsp_types_pkg::sample_lane_u im;
    } complex_beat_t;

    // the complex weight of one channel
    // the same weight applies to every sample position of the beat
    typedef struct packed {
        dsp_types_pkg::weight_t re;
        dsp_types_pkg::weight_t im;
    } complex_weight_t;

endpackage

`default_nettype wire

/* hw/beam_settings.svh */
`ifndef BEAM_SETTINGS_SVH
`define BEAM_SETTINGS_SVH

// bits in one signed sample of a lane
`define BEAM_SAMPLE_WIDTH 8

// samples carried side by side in one lane of a beat
`define BEAM_SAMPLES_PER_BEAT 16

// fraction bits of a channel weight, so a weight is always below one
`define BEAM_WEIGHT_FRAC 7

// antenna channels that are combined into the beam
`define BEAM_CHANNELS 4

// flat width of one lane as it appears on the top-level ports
`define BEAM_LANE_WIDTH (`BEAM_SAMPLE_WIDTH * `BEAM_SAMPLES_PER_BEAT)

`endif

/* hw/channel_weighter.sv */
`default_nettype none

`include "beam_settings.svh"

// multiplies every sample of a complex beat by the channel weight
// the product is rounded half up, saturated to a sample and held in one register stage
module channel_weighter (
    input  logic                       clock,
    input  logic                       resetn,
    input  logic                       in_valid,
    output logic                       in_ready,
    input  beam_pkg::complex_beat_t    in_beat,
    input  beam_pkg::complex_weight_t  weight,
    beam_lane_if.source                out
);

    localparam int FRAC = `BEAM_WEIGHT_FRAC;
    localparam int SAMPLE_MAX = 2 ** (`BEAM_SAMPLE_WIDTH - 1) - 1;
    localparam int SAMPLE_MIN = -(2 ** (`BEAM_SAMPLE_WIDTH - 1));

    // half of one output step in product units, added before the shift
    localparam dsp_types_pkg::product_t ROUND = 1 <<< (FRAC - 1);

    beam_pkg::complex_beat_t weighted;
    beam_pkg::complex_beat_t beat_q;
    logic                    valid_q;
    logic                    take;

    // scales a product back to sample units and clips it to the sample range
    function automatic dsp_types_pkg::sample_t round_saturate(
        input dsp_types_pkg::product_t value
    );
        dsp_types_pkg::product_t scaled;
        scaled = (value + ROUND) >>> FRAC;
        // the cross terms can push a complex product past either end of the range
        if (scaled > SAMPLE_MAX) begin
            return dsp_types_pkg::sample_t'(SAMPLE_MAX);
        end else if (scaled < SAMPLE_MIN) begin
            return dsp_types_pkg::sample_t'(SAMPLE_MIN);
        end
        return scaled[`BEAM_SAMPLE_WIDTH-1:0];
    endfunction

    // the register can take a new beat when it is empty or is being emptied
    assign in_ready = !valid_q || out.ready;
    assign take     = in_valid && in_ready;

    // complex multiply per sample position
    always_comb begin
        dsp_types_pkg::sample_t  xr;
        dsp_types_pkg::sample_t  xi;
        dsp_types_pkg::product_t prod_re;
        dsp_types_pkg::product_t prod_im;
        for (int i = 0; i < `BEAM_SAMPLES_PER_BEAT; i++) begin
            xr = in_beat.re.samples[i];
            xi = in_beat.im.samples[i];
            // all operands are signed, so they widen to the product width before multiplying
            prod_re = weight.re * xr - weight.im * xi;
            prod_im = weight.re * xi + weight.im * xr;
            weighted.re.samples[i] = round_saturate(prod_re);
            weighted.im.samples[i] = round_saturate(prod_im);
        end
    end

    // output valid follows the input transfer by one cycle
    always_ff @(posedge clock) begin
        if (!resetn) begin
            valid_q <= 1'b0;
        end else if (take) begin
            valid_q <= 1'b1;
        end else if (out.ready) begin
            valid_q <= 1'b0;
        end
    end

    // the weight in use is the one present on the edge of the input transfer
    always_ff @(posedge clock) begin
        if (take) begin
            beat_q <= weighted;
        end
    end

    assign out.valid = valid_q;
    assign out.beat  = beat_q;

    // a channel that offers a beat keeps valid and the beat until it is taken
    a_in_held: assert property (
        @(posedge clock) disable iff (!resetn)
        in_valid && !in_ready |=> in_valid && $stable(in_beat)
    );

endmodule

`default_nettype wire

/* hw/dsp_types_pkg.sv */
`default_nettype none

`include "beam_settings.svh"

// numeric formats shared by the weighting and combining arithmetic
package dsp_types_pkg;

    // one signed input or output sample
    typedef logic signed [`BEAM_SAMPLE_WIDTH-1:0] sample_t;

    // signed weight with `BEAM_WEIGHT_FRAC fraction bits
    typedef logic signed [`BEAM_SAMPLE_WIDTH-1:0] weight_t;

    // a sum or difference of two sample by weight products
    // one bit wider than a single product so the sum never wraps
    typedef logic signed [2*`BEAM_SAMPLE_WIDTH:0] product_t;

    // one lane of a beat, seen either as flat bits or as separate samples
    // sample 0 sits in the lowest bits of the flat view
    typedef union packed {
        logic [`BEAM_LANE_WIDTH-1:0] bits;
        sample_t [`BEAM_SAMPLES_PER_BEAT-1:0] samples;
    } sample_lane_u;

endpackage

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# builds the beamformer testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal \
    -f files.f --top-module beam_former_tb -o beam_sim
./obj_dir/beam_sim

/* tests/beam_former_tb.sv */
`default_nettype none

`include "beam_settings.svh"

// testbench for the four-channel beamformer
// records come from the golden file, channel valids and beam_ready follow an xorshift sequence
module beam_former_tb;

    localparam int LW = `BEAM_LANE_WIDTH;
    localparam int CH = `BEAM_CHANNELS;
    localparam int TIMEOUT = 2000;

    logic clock;
    logic resetn;
    logic beam_ready;
    logic beam_valid;
    logic [LW-1:0] beam_real;
    logic [LW-1:0] beam_imag;
    logic ch_valid [CH];
    logic ch_ready [CH];
    logic [LW-1:0] ch_re [CH];
    logic [LW-1:0] ch_im [CH];
    logic [`BEAM_SAMPLE_WIDTH-1:0] w_re [CH];
    logic [`BEAM_SAMPLE_WIDTH-1:0] w_im [CH];

    // beats that the driver still has to hand over, one per channel
    logic pending [CH];
    logic [LW-1:0] exp_re_q [$];
    logic [LW-1:0] exp_im_q [$];
    logic [31:0] rng_state;

    beam_former_top beam_former_top_i (
        .clock(clock), .resetn(resetn),
        .ch00_valid(ch_valid[0]), .ch00_ready(ch_ready[0]),
        .ch00_real(ch_re[0]), .ch00_imag(ch_im[0]),
        .ch00_weight_real(w_re[0]), .ch00_weight_imag(w_im[0]),
        .ch01_valid(ch_valid[1]), .ch01_ready(ch_ready[1]),
        .ch01_real(ch_re[1]), .ch01_imag(ch_im[1]),
        .ch01_weight_real(w_re[1]), .ch01_weight_imag(w_im[1]),
        .ch20_valid(ch_valid[2]), .ch20_ready(ch_ready[2]),
        .ch20_real(ch_re[2]), .ch20_imag(ch_im[2]),
        .ch20_weight_real(w_re[2]), .ch20_weight_imag(w_im[2]),
        .ch21_valid(ch_valid[3]), .ch21_ready(ch_ready[3]),
        .ch21_real(ch_re[3]), .ch21_imag(ch_im[3]),
        .ch21_weight_real(w_re[3]), .ch21_weight_imag(w_im[3]),
        .beam_valid(beam_valid), .beam_ready(beam_ready),
        .beam_real(beam_real), .beam_imag(beam_imag)
    );

    always #20 clock = ~clock;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic report_mismatch(input string name, input logic [LW-1:0] expected,
                                   input logic [LW-1:0] actual);
        $display("ERR t=%0t %s expected %h actual %h", $time, name, expected, actual);
        $display("STATUS: FAIL");
        $fatal(1);
    endtask

    task automatic report_failure(input string what);
        $display("%s at t=%0t", what, $time);
        $display("STATUS: FAIL");
        $fatal(1);
    endtask

    // one clock cycle of stimulus
    // handshakes are judged at the falling edge, where every signal is settled
    task automatic step();
        logic [CH-1:0] fire;
        @(negedge clock);
        for (int c = 0; c < CH; c++) begin
            fire[c] = ch_valid[c] && ch_ready[c];
        end
        @(posedge clock);
        for (int c = 0; c < CH; c++) begin
            rng_state = xorshift(rng_state);
            if (fire[c]) begin
                ch_valid[c] <= 1'b0;
                pending[c] = 1'b0;
            end else if (pending[c] && !ch_valid[c] && rng_state[3]) begin
                ch_valid[c] <= 1'b1;
            end
        end
        // beam_ready is low about one cycle in four
        rng_state = xorshift(rng_state);
        beam_ready <= (rng_state[5:4] != 2'b00);
    endtask

    function automatic logic any_pending();
        logic busy;
        busy = 1'b0;
        for (int c = 0; c < CH; c++) begin
            busy = busy | pending[c];
        end
        return busy;
    endfunction

    // every beam transfer must match the oldest expected beat
    initial begin
        forever begin
            @(negedge clock);
            if (resetn && beam_valid && beam_ready) begin
                assert (exp_re_q.size() > 0)
                else report_failure("beam beat delivered while none was expected");
                assert (beam_real == exp_re_q[0])
                else report_mismatch("beam_real", exp_re_q[0], beam_real);
                assert (beam_imag == exp_im_q[0])
                else report_mismatch("beam_imag", exp_im_q[0], beam_imag);
                void'(exp_re_q.pop_front());
                void'(exp_im_q.pop_front());
            end
        end
    end

    initial begin
        int fd;
        int n;
        int count;
        logic [15:0] tag;
        logic [8*256-1:0] skip;
        logic [`BEAM_SAMPLE_WIDTH-1:0] wv [2*CH];
        logic [LW-1:0] er;
        logic [LW-1:0] ei;
        clock = 1'b0;
        resetn = 1'b0;
        beam_ready = 1'b1;
        rng_state = 32'hdd96;
        for (int c = 0; c < CH; c++) begin
            ch_valid[c] = 1'b0;
            ch_re[c] = '0;
            ch_im[c] = '0;
            w_re[c] = '0;
            w_im[c] = '0;
            pending[c] = 1'b0;
        end
        repeat (10) @(posedge clock);
        resetn <= 1'b1;
        @(negedge clock);
        assert (beam_valid == 1'b0) else report_mismatch("beam_valid", 0, beam_valid);
        for (int c = 0; c < CH; c++) begin
            assert (ch_ready[c] == 1'b1) else report_mismatch("ch_ready", 1, ch_ready[c]);
        end
        fd = $fopen("tests/beam_golden.txt", "r");
        if (fd == 0) report_failure("golden file could not be opened");
        while (!$feof(fd)) begin
            n = $fscanf(fd, "%s", tag);
            if (n != 1) break;
            if (tag == "#") begin
                n = $fgets(skip, fd);
            end else if (tag == "W") begin
                for (int k = 0; k < 2 * CH; k++) begin
                    n = $fscanf(fd, "%h", wv[k]);
                end
                // the pipeline drains before the new weights apply
                count = 0;
                while (exp_re_q.size() != 0 && count < TIMEOUT) begin
                    step();
                    count++;
                end
                if (exp_re_q.size() != 0) report_failure("pipeline did not drain");
                @(posedge clock);
                for (int c = 0; c < CH; c++) begin
                    w_re[c] <= wv[2*c];
                    w_im[c] <= wv[2*c+1];
                end
            end else if (tag == "V") begin
                n = $fscanf(fd, "%h %h", er, ei);
                exp_re_q.push_back(er);
                exp_im_q.push_back(ei);
                // lanes may change now, since no channel holds valid between records
                for (int c = 0; c < CH; c++) begin
                    n = $fscanf(fd, "%h %h", er, ei);
                    ch_re[c] <= er;
                    ch_im[c] <= ei;
                    pending[c] = 1'b1;
                end
                count = 0;
                while (any_pending() && count < TIMEOUT) begin
                    step();
                    count++;
                end
                if (any_pending()) report_failure("a channel beat was never accepted");
            end else begin
                report_failure("unknown record type in golden file");
            end
        end
        $fclose(fd);
        count = 0;
        while (exp_re_q.size() != 0 && count < TIMEOUT) begin
            step();
            count++;
        end
        if (exp_re_q.size() != 0) begin
            report_failure("expected beam beats never arrived");
        end else begin
            $display("STATUS: PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* tests/beam_golden.txt */
# W: weight real and imag, hex bytes, for ch00 ch01 ch20 ch21
# V: expected beam real and imag lanes, then real and imag lanes of ch00 ch01 ch20 ch21
# a lane is 32 hex digits, sample 15 first and sample 0 last
W 7f 00 00 00 00 00 00 00
V 10101010101010101010101010101010 f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0
40404040404040404040404040404040 c0c0c0c0c0c0c0c0c0c0c0c0c0c0c0c0
7f7f7f7f7f7f7f7f7f7f7f7f7f7f7f7f 80808080808080808080808080808080
55555555555555555555555555555555 33333333333333333333333333333333
01010101010101010101010101010101 ffffffffffffffffffffffffffffffff
V 04040303030302020202010101010000 00000000000000000000000000000000
0f0e0d0c0b0a09080706050403020100 00000000000000000000000000000000
7f7f7f7f7f7f7f7f7f7f7f7f7f7f7f7f 7f7f7f7f7f7f7f7f7f7f7f7f7f7f7f7f
80808080808080808080808080808080 80808080808080808080808080808080
00000000000000000000000000000000 00000000000000000000000000000000
W 40 40 40 40 40 40 40 40
V 04040404040404040404040404040404 0c0c0c0c0c0c0c0c0c0c0c0c0c0c0c0c
10101010101010101010101010101010 08080808080808080808080808080808
10101010101010101010101010101010 08080808080808080808080808080808
10101010101010101010101010101010 08080808080808080808080808080808
10101010101010101010101010101010 08080808080808080808080808080808
V ffffffffffffffffffffffffffffffff fdfdfdfdfdfdfdfdfdfdfdfdfdfdfdfd
f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0 f8f8f8f8f8f8f8f8f8f8f8f8f8f8f8f8
f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0 f8f8f8f8f8f8f8f8f8f8f8f8f8f8f8f8
00000000000000000000000000000000 02020202020202020202020202020202
10101010101010101010101010101010 08080808080808080808080808080808
W 80 00 00 00 00 00 00 00
V 20202020202020202020202020202020 20202020202020202020202020202020
80808080808080808080808080808080 80808080808080808080808080808080
7f7f7f7f7f7f7f7f7f7f7f7f7f7f7f7f 7f7f7f7f7f7f7f7f7f7f7f7f7f7f7f7f
12121212121212121212121212121212 34343434343434343434343434343434
80808080808080808080808080808080 01010101010101010101010101010101
V f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0 00000000000000000000000000000000
40404040404040404040404040404040 00000000000000000000000000000000
22222222222222222222222222222222 eeeeeeeeeeeeeeeeeeeeeeeeeeeeeeee
5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5
7f7f7f7f7f7f7f7f7f7f7f7f7f7f7f7f 80808080808080808080808080808080
